//--- logic/div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// data and word widths
`define XLEN        64
`define WORD_W      32

`define REG_ADDR_W  5

// one quotient bit per loop iteration
`define DIV_COUNT_W 7
`define DIV_ITERS   64

`endif

//--- logic/div_pkg.sv
`include "div_defines.svh"

package div_pkg;

    typedef logic [`XLEN-1:0]        dword_t;
    typedef logic [`REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`DIV_COUNT_W-1:0] div_count_t;

    // funct3 of the M extension divide group
    typedef enum logic [2:0] {
        DIV  = 3'd4,
        DIVU = 3'd5,
        REM  = 3'd6,
        REMU = 3'd7
    } div_func_e;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } core_state_e;

    // what the result stage needs to finish a loop division
    typedef struct packed {
        logic      rem_op;
        logic      word_op;
        logic      quot_neg;
        logic      rem_neg;
        reg_addr_t rd_addr;
    } div_ctx_t;

endpackage

//--- logic/div_decode.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_decode
    import div_pkg::*;
(
    input  logic      div_instr_i,
    input  logic      flush_i,
    input  div_func_e div_func_i,
    input  logic      word_op_i,
    input  reg_addr_t rd_addr_i,
    input  dword_t    opr_a_i,
    input  dword_t    opr_b_i,

    output logic      start_o,
    output dword_t    dividend_mag_o,
    output dword_t    divisor_mag_o,
    output div_ctx_t  ctx_o,

    output logic      special_valid_o,
    output dword_t    special_res_o,
    output reg_addr_t special_rd_o
);

    logic   rem_op;
    logic   signed_op;
    dword_t a_ext;
    dword_t b_ext;
    dword_t a_word_sext;
    logic   a_neg;
    logic   b_neg;
    logic   div_zero;
    logic   overflow;
    logic   zero_dividend;
    logic   special;
    logic   accept;

    // narrow a word operand, extended by signedness
    function automatic dword_t narrow_word(input dword_t val, input logic sgn);
        logic ext_bit;
        ext_bit = sgn & val[`WORD_W-1];
        return {{(`XLEN-`WORD_W){ext_bit}}, val[`WORD_W-1:0]};
    endfunction

    assign rem_op    = (div_func_i == REM) || (div_func_i == REMU);
    assign signed_op = (div_func_i == DIV) || (div_func_i == REM);

    assign a_ext = word_op_i ? narrow_word(opr_a_i, signed_op) : opr_a_i;
    assign b_ext = word_op_i ? narrow_word(opr_b_i, signed_op) : opr_b_i;

    // remainder of a word divide by zero is always sign extended
    assign a_word_sext = narrow_word(opr_a_i, 1'b1);

    assign a_neg = signed_op & a_ext[`XLEN-1];
    assign b_neg = signed_op & b_ext[`XLEN-1];

    // most negative value over minus one, in either width
    assign div_zero      = (b_ext == '0);
    assign overflow      = signed_op && (b_ext == '1) &&
                           (word_op_i ? (a_ext == narrow_word(dword_t'(1) << (`WORD_W-1), 1'b1))
                                      : (a_ext == (dword_t'(1) << (`XLEN-1))));
    assign zero_dividend = (a_ext == '0);

    assign special = div_zero | overflow | zero_dividend;
    assign accept  = div_instr_i & ~flush_i;

    always_comb begin
        if (div_zero) begin
            special_res_o = rem_op ? (word_op_i ? a_word_sext : opr_a_i) : '1;
        end else if (overflow) begin
            // a_ext already holds the most negative value of the width
            special_res_o = rem_op ? '0 : a_ext;
        end else begin
            special_res_o = '0;
        end
    end

    assign special_valid_o = accept & special;
    assign special_rd_o    = rd_addr_i;

    assign start_o        = accept & ~special;
    assign dividend_mag_o = a_neg ? -a_ext : a_ext;
    assign divisor_mag_o  = b_neg ? -b_ext : b_ext;

    always_comb begin
        ctx_o          = '0;
        ctx_o.rem_op   = rem_op;
        ctx_o.word_op  = word_op_i;
        ctx_o.quot_neg = a_neg ^ b_neg;
        // remainder follows the dividend sign
        ctx_o.rem_neg  = a_neg;
        ctx_o.rd_addr  = rd_addr_i;
    end

endmodule

//--- logic/div_core.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_core
    import div_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   start_i,
    input  logic   flush_i,
    input  dword_t dividend_i,
    input  dword_t divisor_i,

    output logic   done_o,
    output dword_t quotient_o,
    output dword_t remainder_o,
    output logic   busy_o
);

    core_state_e      state_q;
    div_count_t       count_q;
    logic             done_q;
    dword_t           rem_q;
    dword_t           quot_q;
    dword_t           divisor_q;
    logic [`XLEN:0]   rem_shift;
    logic [`XLEN:0]   rem_diff;
    logic             q_bit;
    logic             last_iter;

    // next dividend bit enters from the top of the quotient register
    assign rem_shift = {rem_q, quot_q[`XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};
    assign q_bit     = ~rem_diff[`XLEN];
    assign last_iter = (count_q == div_count_t'(`DIV_ITERS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            count_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        count_q <= '0;
                    end
                end
                RUN: begin
                    if (flush_i) begin
                        state_q <= IDLE;
                    end else begin
                        count_q <= count_q + div_count_t'(1);
                        if (last_iter) begin
                            state_q <= IDLE;
                            done_q  <= 1'b1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // restoring step, keep the difference only when it did not go negative
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            rem_q     <= '0;
            quot_q    <= dividend_i;
            divisor_q <= divisor_i;
        end else if (state_q == RUN) begin
            rem_q  <= q_bit ? rem_diff[`XLEN-1:0] : rem_shift[`XLEN-1:0];
            quot_q <= {quot_q[`XLEN-2:0], q_bit};
        end
    end

    assign done_o      = done_q;
    assign quotient_o  = quot_q;
    assign remainder_o = rem_q;
    assign busy_o      = (state_q == RUN);

    // issuer has to respect the stall
    a_no_start_in_run: assert property (@(posedge clk) disable iff (reset)
        start_i |-> state_q == IDLE);

    // done only closes a full run of the loop
    a_done_from_run: assert property (@(posedge clk) disable iff (reset)
        done_o |-> $past(start_i, `DIV_ITERS + 1));

endmodule

//--- logic/div_result.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module div_result
    import div_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      start_i,
    input  div_ctx_t  ctx_i,
    input  logic      special_valid_i,
    input  dword_t    special_res_i,
    input  reg_addr_t special_rd_i,

    input  logic      done_i,
    input  dword_t    quotient_i,
    input  dword_t    remainder_i,
    input  logic      busy_i,

    output dword_t    div_res_o,
    output logic      valid_res_o,
    output reg_addr_t rd_addr_o,
    output logic      div_stall_o
);

    div_ctx_t ctx_q;
    dword_t   mag;
    logic     neg;
    dword_t   signed_val;
    dword_t   loop_res;

    always_ff @(posedge clk) begin
        if (start_i) begin
            ctx_q <= ctx_i;
        end
    end

    assign mag        = ctx_q.rem_op ? remainder_i : quotient_i;
    assign neg        = ctx_q.rem_op ? ctx_q.rem_neg : ctx_q.quot_neg;
    assign signed_val = neg ? -mag : mag;
    assign loop_res   = ctx_q.word_op ?
                        {{(`XLEN-`WORD_W){signed_val[`WORD_W-1]}}, signed_val[`WORD_W-1:0]} :
                        signed_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_res_o   <= '0;
            valid_res_o <= 1'b0;
            rd_addr_o   <= '0;
            div_stall_o <= 1'b0;
        end else begin
            valid_res_o <= special_valid_i | done_i;
            // stall stays up through the cycle that delivers the result
            div_stall_o <= busy_i | done_i;
            if (special_valid_i) begin
                div_res_o <= special_res_i;
                rd_addr_o <= special_rd_i;
            end else if (done_i) begin
                div_res_o <= loop_res;
                rd_addr_o <= ctx_q.rd_addr;
            end
        end
    end

    a_one_source: assert property (@(posedge clk) disable iff (reset)
        !(special_valid_i && done_i));

endmodule

//--- logic/divide_unit.sv
`timescale 1ns/1ps

module divide_unit
    import div_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      div_instr_i,
    input  div_func_e div_func_i,
    input  logic      word_op_i,
    input  reg_addr_t rd_addr_i,
    input  dword_t    opr_a_i,
    input  dword_t    opr_b_i,
    input  logic      flush_i,

    output dword_t    div_res_o,
    output logic      valid_res_o,
    output reg_addr_t rd_addr_o,
    output logic      div_stall_o
);

    logic      start;
    dword_t    dividend_mag;
    dword_t    divisor_mag;
    div_ctx_t  ctx;
    logic      special_valid;
    dword_t    special_res;
    reg_addr_t special_rd;
    logic      core_done;
    dword_t    quotient;
    dword_t    remainder;
    logic      core_busy;

    div_decode i_decode (
        .div_instr_i     (div_instr_i),
        .flush_i         (flush_i),
        .div_func_i      (div_func_i),
        .word_op_i       (word_op_i),
        .rd_addr_i       (rd_addr_i),
        .opr_a_i         (opr_a_i),
        .opr_b_i         (opr_b_i),
        .start_o         (start),
        .dividend_mag_o  (dividend_mag),
        .divisor_mag_o   (divisor_mag),
        .ctx_o           (ctx),
        .special_valid_o (special_valid),
        .special_res_o   (special_res),
        .special_rd_o    (special_rd)
    );

    div_core i_core (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start),
        .flush_i     (flush_i),
        .dividend_i  (dividend_mag),
        .divisor_i   (divisor_mag),
        .done_o      (core_done),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .busy_o      (core_busy)
    );

    div_result i_result (
        .clk             (clk),
        .reset           (reset),
        .start_i         (start),
        .ctx_i           (ctx),
        .special_valid_i (special_valid),
        .special_res_i   (special_res),
        .special_rd_i    (special_rd),
        .done_i          (core_done),
        .quotient_i      (quotient),
        .remainder_i     (remainder),
        .busy_i          (core_busy),
        .div_res_o       (div_res_o),
        .valid_res_o     (valid_res_o),
        .rd_addr_o       (rd_addr_o),
        .div_stall_o     (div_stall_o)
    );

endmodule

//--- tb/divide_unit_tb.sv
`timescale 1ns/1ps
`include "div_defines.svh"

module divide_unit_tb
    import div_pkg::*;
();

    localparam int VEC_MAX        = 64;
    localparam int VEC_FIELDS     = 7;
    // cycles counted from the edge that samples the strobe
    localparam int SPECIAL_CYCLES = 1;
    localparam int LOOP_CYCLES    = 66;
    localparam int FLUSH_WINDOW   = 70;

    logic      clk;
    logic      reset;
    logic      div_instr;
    div_func_e div_func;
    logic      word_op;
    reg_addr_t rd_addr;
    dword_t    opr_a;
    dword_t    opr_b;
    logic      flush;
    dword_t    div_res;
    logic      valid_res;
    reg_addr_t rd_addr_out;
    logic      div_stall;

    dword_t vec_mem [0:VEC_MAX*VEC_FIELDS-1];
    int     num_vecs;
    int     error_count;
    int     cycle_count = 0;
    int     timeout_limit = VEC_MAX * 80 + 100;

    divide_unit i_dut (
        .clk         (clk),
        .reset       (reset),
        .div_instr_i (div_instr),
        .div_func_i  (div_func),
        .word_op_i   (word_op),
        .rd_addr_i   (rd_addr),
        .opr_a_i     (opr_a),
        .opr_b_i     (opr_b),
        .flush_i     (flush),
        .div_res_o   (div_res),
        .valid_res_o (valid_res),
        .rd_addr_o   (rd_addr_out),
        .div_stall_o (div_stall)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // word form keeps the low half, extended by signedness
    function automatic dword_t extend_operand(input dword_t val, input logic word,
                                              input logic sgn);
        dword_t res;
        res = val;
        if (word) begin
            res = {{(`XLEN-`WORD_W){sgn & val[`WORD_W-1]}}, val[`WORD_W-1:0]};
        end
        return res;
    endfunction

    // zero divisor, most negative over minus one, or zero dividend
    function automatic logic takes_short_path(input div_func_e fn, input logic word,
                                              input dword_t a, input dword_t b);
        logic   sgn;
        dword_t a_x;
        dword_t b_x;
        dword_t most_neg;
        sgn      = (fn == DIV) || (fn == REM);
        a_x      = extend_operand(a, word, sgn);
        b_x      = extend_operand(b, word, sgn);
        most_neg = word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
        return (b_x == '0) || (sgn && (b_x == '1) && (a_x == most_neg)) || (a_x == '0);
    endfunction

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_reset_state();
        if (valid_res !== 1'b0 || div_stall !== 1'b0 || div_res !== '0 ||
            rd_addr_out !== '0) begin
            $display("[ERROR] %0t: outputs not cleared by reset (valid %b stall %b res %h rd %h)",
                     $time, valid_res, div_stall, div_res, rd_addr_out);
            error_count++;
        end
    endtask

    task automatic run_vector(input int idx);
        int        base;
        div_func_e fn;
        logic      word;
        reg_addr_t rd;
        dword_t    a;
        dword_t    b;
        int        flush_after;
        dword_t    expected;
        logic      short_path;
        int        want_cycles;
        int        window;
        logic      exp_valid;
        logic      exp_stall;
        base        = idx * VEC_FIELDS;
        fn          = div_func_e'(vec_mem[base][2:0]);
        word        = vec_mem[base + 1][0];
        rd          = vec_mem[base + 2][`REG_ADDR_W-1:0];
        a           = vec_mem[base + 3];
        b           = vec_mem[base + 4];
        flush_after = int'(vec_mem[base + 5][7:0]);
        expected    = vec_mem[base + 6];
        short_path  = takes_short_path(fn, word, a, b);
        want_cycles = short_path ? SPECIAL_CYCLES : LOOP_CYCLES;
        window      = (flush_after > 0) ? FLUSH_WINDOW : want_cycles + 1;

        while (div_stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        div_instr <= 1'b1;
        div_func  <= fn;
        word_op   <= word;
        rd_addr   <= rd;
        opr_a     <= a;
        opr_b     <= b;
        @(posedge clk);
        div_instr <= 1'b0;

        for (int cyc = 1; cyc <= window; cyc++) begin
            @(negedge clk);
            exp_valid = (flush_after == 0) && (cyc == want_cycles);
            if (valid_res !== exp_valid) begin
                $display("[ERROR] %0t: vector %0d valid_res_o is %b in cycle %0d, expected %b",
                         $time, idx, valid_res, cyc, exp_valid);
                error_count++;
            end
            if (flush_after == 0) begin
                exp_stall = !short_path && (cyc >= 2) && (cyc <= LOOP_CYCLES);
                if (div_stall !== exp_stall) begin
                    $display("[ERROR] %0t: vector %0d div_stall_o is %b in cycle %0d, expected %b",
                             $time, idx, div_stall, cyc, exp_stall);
                    error_count++;
                end
            end
            if (exp_valid && div_res !== expected) begin
                $display("[ERROR] %0t: vector %0d result %h, expected %h",
                         $time, idx, div_res, expected);
                error_count++;
            end
            if (exp_valid && rd_addr_out !== rd) begin
                $display("[ERROR] %0t: vector %0d rd_addr_o %h, expected %h",
                         $time, idx, rd_addr_out, rd);
                error_count++;
            end
            @(posedge clk);
            flush <= (flush_after > 0) && (cyc == flush_after);
        end
    endtask

    initial begin
        div_instr   = 1'b0;
        div_func    = DIVU;
        word_op     = 1'b0;
        rd_addr     = '0;
        opr_a       = '0;
        opr_b       = '0;
        flush       = 1'b0;
        reset       = 1'b1;
        error_count = 0;

        $readmemh("tb/div_vectors.txt", vec_mem);
        num_vecs = 0;
        // a zero function code ends the list
        while (num_vecs < VEC_MAX && vec_mem[num_vecs * VEC_FIELDS] != '0) begin
            num_vecs++;
        end
        timeout_limit = num_vecs * 80 + 100;
        if (num_vecs == 0) begin
            $display("no vectors were read from tb/div_vectors.txt");
            error_count++;
        end

        apply_reset();
        check_reset_state();

        for (int i = 0; i < num_vecs; i++) begin
            run_vector(i);
        end

        $display("%0d vectors run, %0d errors", num_vecs, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb/div_vectors.txt
// func word rd a b flush_after expected, all hex, one request per line
// func 4 DIV 5 DIVU 6 REM 7 REMU, flush_after 0 means no flush
5 0 01 0000000000000064 0000000000000007 0 000000000000000e
7 0 02 0000000000000064 0000000000000007 0 0000000000000002
5 0 03 ffffffffffffffff 0000000000000002 0 7fffffffffffffff
7 0 04 ffffffffffffffff 000000000000000a 0 0000000000000005
5 0 05 123456789abcdef0 0000000000000010 0 0123456789abcdef
7 0 06 123456789abcdef7 0000000000000010 0 0000000000000007
7 0 07 0000000000000005 0000000000000009 0 0000000000000005
5 0 08 8000000000000000 ffffffffffffffff 0 0000000000000000
// signed, truncation toward zero
4 0 09 ffffffffffffff9c 0000000000000007 0 fffffffffffffff2
6 0 0a ffffffffffffff9c 0000000000000007 0 fffffffffffffffe
4 0 0b 0000000000000064 fffffffffffffff9 0 fffffffffffffff2
6 0 0c 0000000000000064 fffffffffffffff9 0 0000000000000002
4 0 0d ffffffffffffff9c fffffffffffffff9 0 000000000000000e
6 0 0e ffffffffffffff9c fffffffffffffff9 0 fffffffffffffffe
4 0 0f 8000000000000000 0000000000000002 0 c000000000000000
// word forms
4 1 10 deadbeefffffff9c 1234567800000007 0 fffffffffffffff2
6 1 11 deadbeefffffff9c 1234567800000007 0 fffffffffffffffe
5 1 12 00000000fffffffe 0000000000000002 0 000000007fffffff
5 1 13 1111111180000000 abcdef0000000001 0 ffffffff80000000
7 1 14 00000000fffffff0 00000000fffffff1 0 fffffffffffffff0
// division by zero
5 0 15 00000000000004d2 0000000000000000 0 ffffffffffffffff
6 0 16 ffffffffffffff9c 0000000000000000 0 ffffffffffffff9c
7 1 17 0000000080000001 1234567800000000 0 ffffffff80000001
4 1 18 0000000000000063 0000000000000000 0 ffffffffffffffff
// signed overflow
4 0 19 8000000000000000 ffffffffffffffff 0 8000000000000000
6 0 1a 8000000000000000 ffffffffffffffff 0 0000000000000000
4 1 1b 0000000080000000 00000000ffffffff 0 ffffffff80000000
// zero dividend
4 0 1c 0000000000000000 0000000000000005 0 0000000000000000
6 1 1d ffffffff00000000 0000000000000003 0 0000000000000000
// flush mid-run, then a normal request
5 0 1e 00000000000003e8 0000000000000003 0a 0000000000000000
5 0 1f 00000000000003e8 0000000000000003 0 000000000000014d
4 0 01 fffffffffffffc18 0000000000000003 3c 0000000000000000
6 0 02 00000000000003e8 fffffffffffffffd 0 0000000000000001
// end of list
0 0 00 0000000000000000 0000000000000000 0 0000000000000000

//--- vlog.f
+incdir+logic
logic/div_pkg.sv
logic/div_decode.sv
logic/div_core.sv
logic/div_result.sv
logic/divide_unit.sv
tb/divide_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := divide_unit_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
